// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := uart_bank_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/uart_bank_chk.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_bank_chk (
   input logic                    clk,
   input logic                    reset,
   input logic                    cyc,
   input logic                    stb,
   input logic                    ack,
   input logic                    irq,
   input logic [`UART_NUM_CH-1:0] txd,
   input logic [`UART_NUM_CH-1:0] tx_busy,
   input uart_pkg::chan_req_t     req [`UART_NUM_CH]
);
   int unsigned             err_cnt = 0;
   logic [`UART_NUM_CH-1:0] strobe;
   logic                    ctrl_wr;
   logic                    ctrl_seen;

   always_comb
   begin
      ctrl_wr = 1'b0;
      for (int i = 0; i < `UART_NUM_CH; i++)
      begin
         strobe[i] = req[i].wr | req[i].rd;
         ctrl_wr = ctrl_wr | (req[i].wr & (req[i].reg_addr == `UART_REG_CTRL));
      end
   end

   // Any control write since reset
   always_ff @(posedge clk)
   begin
      if (reset)
         ctrl_seen <= 1'b0;
      else if (ctrl_wr)
         ctrl_seen <= 1'b1;
   end

   ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
      else
      begin
         err_cnt++;
         $error("ack stayed high for more than one cycle");
      end

   ack_after_req: assert property (@(posedge clk) disable iff (reset) ack |-> $past(cyc & stb))
      else
      begin
         err_cnt++;
         $error("ack rose without a preceding cyc and stb");
      end

   txd_idle_high: assert property (@(posedge clk) disable iff (reset) &(txd | tx_busy))
      else
      begin
         err_cnt++;
         $error("txd low while its transmitter is idle");
      end

   irq_needs_ctrl: assert property (@(posedge clk) disable iff (reset) !ctrl_seen |-> !irq)
      else
      begin
         err_cnt++;
         $error("irq high before any control register write");
      end

   strobe_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(strobe))
      else
      begin
         err_cnt++;
         $error("more than one channel strobed in a cycle");
      end

endmodule

bind uart_bank uart_bank_chk u_chk (
   .clk     (clk),
   .reset   (reset),
   .cyc     (cyc),
   .stb     (stb),
   .ack     (ack),
   .irq     (irq),
   .txd     (txd),
   .tx_busy ({g_ch[3].u_ch.tx_busy,
              g_ch[2].u_ch.tx_busy,
              g_ch[1].u_ch.tx_busy,
              g_ch[0].u_ch.tx_busy}),
   .req     (req)
);

// ==== dv/uart_bank_tb.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_bank_tb;

   localparam int MAX_POLL = 400;
   localparam int MAX_CYC  = 1000;

   // Bits of the status register
   localparam logic [3:0] ST_RXNE   = 4'b0001;
   localparam logic [3:0] ST_TXIDLE = 4'b0010;
   localparam logic [3:0] ST_BRK    = 4'b0100;
   localparam logic [3:0] ST_OVR    = 4'b1000;

   localparam logic [31:0] CTRL_ON = (32'd1 << `UART_CTRL_RX_EN) | (32'd1 << `UART_CTRL_TX_EN);
   localparam logic [31:0] CTRL_IE = CTRL_ON | (32'd1 << `UART_CTRL_RX_IE);

   logic                    clk;
   logic                    reset;
   logic                    cyc;
   logic                    stb;
   logic                    we;
   logic [`UART_ADDR_W-1:0] adr;
   logic [31:0]             dat_w;
   logic [31:0]             dat_r;
   logic                    ack;
   logic [`UART_NUM_CH-1:0] txd;
   logic [`UART_NUM_CH-1:0] rxd;
   logic [`UART_NUM_CH-1:0] force_low;
   logic                    irq;
   integer                  seed = 98;
   logic [7:0]              sent [`UART_NUM_CH];

   // Channel i feeds channel i+1
   assign rxd = {txd[`UART_NUM_CH-2:0], txd[`UART_NUM_CH-1]} & ~force_low;

   uart_bank dut (
      .clk   (clk),
      .reset (reset),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack),
      .txd   (txd),
      .rxd   (rxd),
      .irq   (irq)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [`UART_ADDR_W-1:0] reg_adr(input int ch, input logic [3:0] r);
      return {2'(ch), r};
   endfunction

   function automatic logic [31:0] reg_pattern(input int ch, input logic [3:0] r);
      return 32'h5A00_00C0 | (32'(ch) << 16) | (32'(r) << 8);  // RX/TX enables stay clear
   endfunction

   task automatic fail_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
      assert (act === exp)
      else
      begin
         $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   task automatic wait_ack();
      int n;
      n = 0;
      @(posedge clk);
      while (!ack)
      begin
         n++;
         if (n > 16)
            fail_timeout("bus acknowledge");
         @(posedge clk);
      end
   endtask

   task automatic wb_write(input int ch, input logic [3:0] r, input logic [31:0] data);
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we <= 1'b1;
      adr <= reg_adr(ch, r);
      dat_w <= data;
      wait_ack();
      cyc <= 1'b0;
      stb <= 1'b0;
      we <= 1'b0;
   endtask

   task automatic wb_read(input int ch, input logic [3:0] r, output logic [31:0] data);
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we <= 1'b0;
      adr <= reg_adr(ch, r);
      wait_ack();
      data = dat_r;  // Valid while ack is high
      cyc <= 1'b0;
      stb <= 1'b0;
   endtask

   task automatic read_check(input int ch, input logic [3:0] r, input logic [31:0] exp);
      logic [31:0] v;
      wb_read(ch, r, v);
      check_val($sformatf("dat_r ch%0d reg%0d", ch, r), v, exp);
   endtask

   // Channels up to last_ch hold their patterns and the rest their reset values
   task automatic check_regs(input int last_ch);
      logic [31:0] exp;
      for (int ch = 0; ch < `UART_NUM_CH; ch++)
         for (int r = 0; r < 16; r++)
            if (r == 2 || r == 3 || r >= 12)
            begin
               if (ch <= last_ch)
                  exp = reg_pattern(ch, 4'(r));
               else if (4'(r) == `UART_REG_CPB)
                  exp = `UART_CPB_RESET;
               else
                  exp = 32'd0;
               read_check(ch, 4'(r), exp);
            end
   endtask

   task automatic send_byte(input int ch, input logic [7:0] b);
      wb_write(ch, `UART_REG_DR, {24'd0, b});
   endtask

   // Read status until the masked bits match, return the last word
   task automatic poll_status(input int ch, input logic [3:0] mask, input logic [3:0] want,
                              input string what, output logic [31:0] v);
      int n;
      n = 0;
      wb_read(ch, `UART_REG_STAT, v);
      while ((v[3:0] & mask) != want)
      begin
         n++;
         if (n > MAX_POLL)
            fail_timeout(what);
         wb_read(ch, `UART_REG_STAT, v);
      end
   endtask

   task automatic wait_irq();
      int n;
      n = 0;
      @(posedge clk);
      while (!irq)
      begin
         n++;
         if (n > MAX_CYC)
            fail_timeout("irq to rise");
         @(posedge clk);
      end
   endtask

   initial
   begin
      logic [31:0] v;
      logic [7:0]  b;
      logic [7:0]  b2;
      int          nx;

      reset <= 1'b1;
      cyc <= 1'b0;
      stb <= 1'b0;
      we <= 1'b0;
      adr <= '0;
      dat_w <= '0;
      force_low <= '0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      check_regs(-1);

      // Distinct values per channel, so any cross-channel write shows up
      for (int ch = 0; ch < `UART_NUM_CH; ch++)
      begin
         for (int r = 0; r < 16; r++)
            if (r == 2 || r == 3 || r >= 12)
               wb_write(ch, 4'(r), reg_pattern(ch, 4'(r)));
         check_regs(ch);
      end

      for (int ch = 0; ch < `UART_NUM_CH; ch++)
      begin
         wb_write(ch, `UART_REG_CPB, 32'd8);
         wb_write(ch, `UART_REG_CTRL, CTRL_ON);
      end
      for (int ch = 0; ch < `UART_NUM_CH; ch++)
      begin
         sent[ch] = 8'($random(seed));
         send_byte(ch, sent[ch]);
      end
      for (int ch = 0; ch < `UART_NUM_CH; ch++)
      begin
         nx = (ch + 1) % `UART_NUM_CH;
         poll_status(nx, ST_RXNE, ST_RXNE, "loopback byte", v);
         read_check(nx, `UART_REG_DR, {24'd0, sent[ch]});
         wb_read(nx, `UART_REG_STAT, v);
         check_val("rx_not_empty", {31'd0, v[0]}, 32'd0);
      end

      b = 8'($random(seed));
      send_byte(0, b);
      wb_read(0, `UART_REG_STAT, v);
      check_val("tx_idle", {31'd0, v[1]}, 32'd0);
      send_byte(0, ~b);  // Transmitter busy
      poll_status(0, ST_TXIDLE, ST_TXIDLE, "end of frame", v);
      poll_status(1, ST_RXNE, ST_RXNE, "first byte", v);
      read_check(1, `UART_REG_DR, {24'd0, b});
      repeat (200) @(posedge clk);  // Room for a stray second frame
      wb_read(1, `UART_REG_STAT, v);
      check_val("rx_not_empty", {31'd0, v[0]}, 32'd0);

      wb_write(0, `UART_REG_CTRL, 32'd1 << `UART_CTRL_RX_EN);
      send_byte(0, b ^ 8'h5A);
      wb_read(0, `UART_REG_STAT, v);
      check_val("tx_idle", {31'd0, v[1]}, 32'd1);
      repeat (200) @(posedge clk);
      wb_read(1, `UART_REG_STAT, v);
      check_val("rx_not_empty", {31'd0, v[0]}, 32'd0);
      wb_write(0, `UART_REG_CTRL, CTRL_ON);

      b = 8'($random(seed));
      b2 = 8'($random(seed));
      send_byte(0, b);
      poll_status(0, ST_TXIDLE, ST_TXIDLE, "end of first frame", v);
      send_byte(0, b2);
      poll_status(1, ST_OVR, ST_OVR, "overrun", v);
      check_val("status", v, {28'd0, ST_OVR | ST_TXIDLE | ST_RXNE});
      read_check(1, `UART_REG_STAT, {28'd0, ST_TXIDLE | ST_RXNE});
      read_check(1, `UART_REG_DR, {24'd0, b2});
      read_check(1, `UART_REG_STAT, {28'd0, ST_TXIDLE});

      wb_write(1, `UART_REG_CTRL, CTRL_IE);
      check_val("irq", {31'd0, irq}, 32'd0);
      b = 8'($random(seed));
      send_byte(0, b);
      wait_irq();
      read_check(1, `UART_REG_DR, {24'd0, b});
      check_val("irq", {31'd0, irq}, 32'd0);
      wb_write(1, `UART_REG_CTRL, CTRL_ON);
      b = 8'($random(seed));
      send_byte(0, b);
      poll_status(1, ST_RXNE, ST_RXNE, "byte without interrupt", v);
      check_val("irq", {31'd0, irq}, 32'd0);
      read_check(1, `UART_REG_DR, {24'd0, b});

      @(posedge clk);
      force_low <= 4'b0010;
      poll_status(1, ST_BRK, ST_BRK, "break detect", v);
      @(posedge clk);
      force_low <= '0;
      poll_status(1, ST_BRK, 4'b0000, "break release", v);
      check_val("status", v, {28'd0, ST_TXIDLE});

      if (dut.u_chk.err_cnt == 0)
      begin
         $display("** PASS **");
         $finish;
      end
      else
      begin
         $display("Protocol assertions failed %0d times", dut.u_chk.err_cnt);
         $display("** FAIL **");
         $fatal(1);
      end
   end

endmodule

// ==== flist.f ====
+incdir+include
hw/uart_pkg.sv
hw/uart_wb_slave.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_channel.sv
hw/uart_collect.sv
hw/uart_bank.sv
dv/uart_bank_chk.sv
dv/uart_bank_tb.sv

// ==== hw/uart_bank.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_bank (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    cyc,
   input  logic                    stb,
   input  logic                    we,
   input  logic [`UART_ADDR_W-1:0] adr,
   input  logic [31:0]             dat_w,
   output logic [31:0]             dat_r,
   output logic                    ack,
   output logic [`UART_NUM_CH-1:0] txd,
   input  logic [`UART_NUM_CH-1:0] rxd,
   output logic                    irq
);
   import uart_pkg::*;

   chan_req_t                       req [`UART_NUM_CH];
   chan_rsp_t                       rsp [`UART_NUM_CH];
   logic [$clog2(`UART_NUM_CH)-1:0] ch_sel;
   logic                            rd_stb;

   always_comb
   begin
      rd_stb = 1'b0;
      for (int i = 0; i < `UART_NUM_CH; i++)
         rd_stb = rd_stb | req[i].rd;
   end

   uart_wb_slave u_slave (
      .clk    (clk),
      .reset  (reset),
      .cyc    (cyc),
      .stb    (stb),
      .we     (we),
      .adr    (adr),
      .dat_w  (dat_w),
      .ack    (ack),
      .ch_sel (ch_sel),
      .req    (req)
   );

   for (genvar i = 0; i < `UART_NUM_CH; i++)
   begin : g_ch
      uart_channel u_ch (
         .clk   (clk),
         .reset (reset),
         .req   (req[i]),
         .rsp   (rsp[i]),
         .rxd   (rxd[i]),
         .txd   (txd[i])
      );
   end

   uart_collect u_collect (
      .clk    (clk),
      .reset  (reset),
      .ch_sel (ch_sel),
      .rd_stb (rd_stb),
      .rsp    (rsp),
      .dat_r  (dat_r),
      .irq    (irq)
   );

endmodule

// ==== hw/uart_channel.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_channel (
   input  logic                clk,
   input  logic                reset,
   input  uart_pkg::chan_req_t req,
   output uart_pkg::chan_rsp_t rsp,
   input  logic                rxd,
   output logic                txd
);
   import uart_pkg::*;

   logic [31:0]  ctrl;
   logic [31:0]  cpb;
   logic [31:0]  scratch [4];
   logic [3:0]   reg_addr_q;
   logic [3:0]   cur_addr;
   logic [7:0]   rx_byte;
   logic         rx_full;
   logic         overrun;
   logic         tx_start;
   logic         tx_busy;
   logic         rx_valid;
   logic         rx_brk;
   logic [7:0]   rx_data;
   logic         pop;
   logic         stat_rd;
   uart_status_t stat;

   // Address of the access in flight, else the last one
   assign cur_addr = (req.wr | req.rd) ? req.reg_addr : reg_addr_q;
   assign tx_start = req.wr & (req.reg_addr == `UART_REG_DR) & ctrl[`UART_CTRL_TX_EN];
   assign pop = req.rd & (req.reg_addr == `UART_REG_DR);
   assign stat_rd = req.rd & (req.reg_addr == `UART_REG_STAT);

   assign stat = '{overrun: overrun, brk: rx_brk, tx_idle: ~tx_busy, rx_not_empty: rx_full};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ctrl <= '0;
         cpb <= `UART_CPB_RESET;
         reg_addr_q <= '0;
         for (int i = 0; i < 4; i++)
            scratch[i] <= '0;
      end
      else
      begin
         if (req.wr | req.rd)
            reg_addr_q <= req.reg_addr;
         if (req.wr)
         begin
            case (req.reg_addr)
               `UART_REG_CTRL: ctrl <= req.wdata;
               `UART_REG_CPB:  cpb <= req.wdata;
               default:
                  if (req.reg_addr[3:2] == 2'b11)  // Scratch 12 to 15
                     scratch[req.reg_addr[1:0]] <= req.wdata;
            endcase
         end
      end
   end

   // Received byte holder
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_full <= 1'b0;
         overrun <= 1'b0;
      end
      else
      begin
         if (rx_valid)
            rx_full <= 1'b1;
         else if (pop)
            rx_full <= 1'b0;
         if (stat_rd)
            overrun <= 1'b0;
         if (rx_valid & rx_full & ~pop)
            overrun <= 1'b1;  // Unread byte lost
      end
   end

   always_ff @(posedge clk)
   begin
      if (rx_valid)
         rx_byte <= rx_data;
   end

   always_comb
   begin
      rsp.rdata = '0;
      case (cur_addr)
         `UART_REG_DR:   rsp.rdata = {24'd0, rx_byte};
         `UART_REG_STAT: rsp.rdata = {28'd0, stat};
         `UART_REG_CTRL: rsp.rdata = ctrl;
         `UART_REG_CPB:  rsp.rdata = cpb;
         default:
            if (cur_addr[3:2] == 2'b11)
               rsp.rdata = scratch[cur_addr[1:0]];
      endcase
      rsp.irq = rx_full & ctrl[`UART_CTRL_RX_IE];
   end

   uart_tx u_tx (
      .clk            (clk),
      .reset          (reset),
      .start          (tx_start),
      .data           (req.wdata[7:0]),
      .cycles_per_bit (cpb),
      .txd            (txd),
      .busy           (tx_busy)
   );

   uart_rx u_rx (
      .clk            (clk),
      .reset          (reset),
      .en             (ctrl[`UART_CTRL_RX_EN]),
      .rxd            (rxd),
      .cycles_per_bit (cpb),
      .valid          (rx_valid),
      .data           (rx_data),
      .brk            (rx_brk)
   );

endmodule

// ==== hw/uart_collect.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_collect (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [$clog2(`UART_NUM_CH)-1:0] ch_sel,
   input  logic                            rd_stb,
   input  uart_pkg::chan_rsp_t             rsp [`UART_NUM_CH],
   output logic [31:0]                     dat_r,
   output logic                            irq
);
   // Read word stays put until the next read
   always_ff @(posedge clk)
   begin
      if (reset)
         dat_r <= '0;
      else if (rd_stb)
         dat_r <= rsp[ch_sel].rdata;
   end

   always_comb
   begin
      irq = 1'b0;
      for (int i = 0; i < `UART_NUM_CH; i++)
         irq = irq | rsp[i].irq;
   end

endmodule

// ==== hw/uart_pkg.sv ====
`include "uart_macros.svh"

package uart_pkg;

   // One bus access routed to a channel
   typedef struct packed {
      logic wr;
      logic rd;
      logic [`UART_ADDR_W-$clog2(`UART_NUM_CH)-1:0] reg_addr;
      logic [31:0] wdata;
   } chan_req_t;

   typedef struct packed {
      logic [31:0] rdata;
      logic        irq;
   } chan_rsp_t;

   // Low bits of the status register
   typedef struct packed {
      logic overrun;       // Cleared by a status read
      logic brk;
      logic tx_idle;
      logic rx_not_empty;
   } uart_status_t;

endpackage

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
   input  logic        clk,
   input  logic        reset,
   input  logic        en,
   input  logic        rxd,
   input  logic [31:0] cycles_per_bit,
   output logic        valid,
   output logic [7:0]  data,
   output logic        brk
);
   typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

   state_t      state;
   logic [2:0]  sync;
   logic [31:0] cnt;
   logic [2:0]  bit_idx;
   logic [7:0]  shreg;
   logic        line;
   logic        fall;
   logic        bit_end;
   logic        half_end;

   assign line = sync[1];              // After two flops
   assign fall = sync[2] & ~sync[1];
   assign bit_end = (cnt + 32'd1 >= cycles_per_bit);
   assign half_end = (cnt + 32'd1 >= (cycles_per_bit >> 1));
   assign data = shreg;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= S_IDLE;
         sync <= 3'b111;
         cnt <= '0;
         bit_idx <= '0;
         valid <= 1'b0;
         brk <= 1'b0;
      end
      else
      begin
         sync <= {sync[1:0], rxd};
         valid <= 1'b0;
         if (brk & line)
            brk <= 1'b0;
         if (!en)
            state <= S_IDLE;
         else
         begin
            case (state)
               S_IDLE:
                  if (fall)
                  begin
                     cnt <= '0;
                     state <= S_START;
                  end
               S_START:  // Check the start bit at mid-period
                  if (half_end)
                  begin
                     cnt <= '0;
                     bit_idx <= '0;
                     state <= line ? S_IDLE : S_DATA;
                  end
                  else
                     cnt <= cnt + 32'd1;
               S_DATA:
                  if (bit_end)
                  begin
                     cnt <= '0;
                     shreg <= {line, shreg[7:1]};  // LSB first
                     bit_idx <= bit_idx + 3'd1;
                     if (bit_idx == 3'd7)
                        state <= S_STOP;
                  end
                  else
                     cnt <= cnt + 32'd1;
               S_STOP:
                  if (bit_end)
                  begin
                     state <= S_IDLE;
                     if (line)
                        valid <= 1'b1;
                     else if (shreg == 8'd0)
                        brk <= 1'b1;  // Whole frame low
                  end
                  else
                     cnt <= cnt + 32'd1;
               default: state <= S_IDLE;
            endcase
         end
      end
   end

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
   input  logic        clk,
   input  logic        reset,
   input  logic        start,
   input  logic [7:0]  data,
   input  logic [31:0] cycles_per_bit,
   output logic        txd,
   output logic        busy
);
   logic [8:0]  shreg;    // Data bits then stop bit
   logic [3:0]  bit_cnt;
   logic [31:0] cnt;
   logic        bit_end;

   assign bit_end = (cnt + 32'd1 >= cycles_per_bit);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         txd <= 1'b1;
         busy <= 1'b0;
         cnt <= '0;
         bit_cnt <= '0;
      end
      else if (!busy)
      begin
         if (start)  // Writes while busy are dropped
         begin
            txd <= 1'b0;
            shreg <= {1'b1, data};
            cnt <= '0;
            bit_cnt <= '0;
            busy <= 1'b1;
         end
      end
      else if (bit_end)
      begin
         cnt <= '0;
         if (bit_cnt == 4'd9)
            busy <= 1'b0;  // End of stop bit
         else
         begin
            txd <= shreg[0];
            shreg <= {1'b1, shreg[8:1]};
            bit_cnt <= bit_cnt + 4'd1;
         end
      end
      else
         cnt <= cnt + 32'd1;
   end

endmodule

// ==== hw/uart_wb_slave.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_wb_slave (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            cyc,
   input  logic                            stb,
   input  logic                            we,
   input  logic [`UART_ADDR_W-1:0]         adr,
   input  logic [31:0]                     dat_w,
   output logic                            ack,
   output logic [$clog2(`UART_NUM_CH)-1:0] ch_sel,
   output uart_pkg::chan_req_t             req [`UART_NUM_CH]
);
   localparam int CH_W = $clog2(`UART_NUM_CH);

   logic            go;
   logic [CH_W-1:0] adr_ch;
   logic [CH_W-1:0] ch_sel_q;

   assign go = cyc & stb & ~ack;  // First cycle of a bus cycle
   assign adr_ch = adr[`UART_ADDR_W-1 -: CH_W];
   assign ch_sel = go ? adr_ch : ch_sel_q;

   // Strobe only the addressed channel
   always_comb
   begin
      for (int i = 0; i < `UART_NUM_CH; i++)
      begin
         req[i] = '0;
         if (go && adr_ch == CH_W'(i))
         begin
            req[i].wr = we;
            req[i].rd = ~we;
            req[i].reg_addr = adr[`UART_ADDR_W-CH_W-1:0];
            req[i].wdata = dat_w;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack <= 1'b0;
         ch_sel_q <= '0;
      end
      else
      begin
         ack <= go;
         if (go)
            ch_sel_q <= adr_ch;
      end
   end

endmodule

// ==== include/uart_macros.svh ====
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Bank geometry
`define UART_NUM_CH 4
`define UART_ADDR_W 6

// Register indices within a channel
`define UART_REG_DR   4'd0
`define UART_REG_STAT 4'd1
`define UART_REG_CTRL 4'd2
`define UART_REG_CPB  4'd3

// Control register bits
`define UART_CTRL_RX_EN 0
`define UART_CTRL_TX_EN 1
`define UART_CTRL_RX_IE 2

`define UART_CPB_RESET 32'd434  // 50 MHz / 115200 baud

`endif
